//--- ddr3_wr_top.f
+incdir+hw
hw/ddr3_wr_pkg.sv
hw/ddr3_wr_cfg_regs.sv
hw/ddr3_wr_seq.sv
hw/ddr3_wr_ctrl.sv
hw/ddr3_wr_pattern_gen.sv
hw/ddr3_wr_top.sv
sim/ddr3_wr_sva.sv
sim/ddr3_wr_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module ddr3_wr_tb \
	-f ddr3_wr_top.f -o ddr3_wr_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/ddr3_wr_sim +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Result: PASSED"; then
	exit 0
fi
exit 1

//--- sim/ddr3_wr_tb.sv
module ddr3_wr_tb;
	import ddr3_wr_pkg::*;

	// 92 beats in all, each allowed a generous stall, plus reset and setup time.
	localparam int TOTAL_BEATS = 4 * 1 + 5 * 8 + 3 * 16;
	localparam int STALL_BOUND = 64;
	localparam int TIMEOUT = (TOTAL_BEATS + 12 * 8) * STALL_BOUND * 40 + 64 * 40;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic reg_we = 1'b0;
	reg_addr_t reg_addr = '0;
	reg_data_t reg_wdata = '0;
	reg_data_t reg_rdata;
	ddr_addr_t axi_awaddr;
	burst_len_t axi_awlen;
	burst_id_t axi_awuser_id;
	logic axi_awuser_ap;
	logic axi_awvalid;
	logic axi_awready = 1'b0;
	ddr_data_t axi_wdata;
	ddr_strb_t axi_wstrb;
	logic axi_wready = 1'b0;
	burst_id_t axi_wusero_id = '0;
	logic axi_wusero_last = 1'b0;

	integer seed = 32'h78afb473;
	int ready_pct = 8; // Ready probability in eighths.
	int pending = 0; // Beats promised but not yet taken.
	burst_id_t cur_id = '0;

	ddr3_wr_top dut_i (.*);

	initial begin
		forever #20 clk = ~clk;
	end

	// Memory controller model: it only offers wready while beats are owed.
	always @(negedge clk) begin
		if (rst_n) begin
			axi_wready = (pending > 0) && (($random(seed) & 7) < ready_pct);
			axi_wusero_last = axi_wready && (pending == 1);
			axi_wusero_id = cur_id;
			if (axi_wready)
				pending = pending - 1;
			axi_awready = ($random(seed) & 7) < ready_pct;
			if (axi_awvalid && axi_awready) begin // Handshake at the next rising edge.
				pending = pending + int'(axi_awlen) + 1;
				cur_id = axi_awuser_id;
			end
		end
	end

	task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
		@(negedge clk);
		reg_we = 1'b1;
		reg_addr = addr;
		reg_wdata = data;
		@(negedge clk);
		reg_we = 1'b0;
	endtask

	task automatic run_config(input ddr_addr_t base, input burst_len_t len, input burst_id_t id,
		input logic ap, input burst_cnt_t count, input int pct);
		ready_pct = pct;
		write_reg(2'd0, reg_data_t'(base));
		write_reg(2'd1, {23'd0, ap, id, len});
		write_reg(2'd2, reg_data_t'(count));
		write_reg(2'd3, 32'd1);
		reg_addr = 2'd3;
		while (!reg_rdata[0])
			@(negedge clk); // Old done may still show until busy appears.
		while (!reg_rdata[1])
			@(negedge clk);
	endtask

	always @(negedge clk) begin
		if (dut_i.sva_i.fail_cnt != 0) begin
			$display("An assertion on the DUT outputs failed");
			$display("Result: FAILED");
			$fatal(1, "Stopping after the first failed check");
		end
	end

	initial begin
		#(TIMEOUT);
		$display("Watchdog expired before all bursts completed");
		$display("Result: FAILED");
		$fatal(1, "Simulation timed out");
	end

	initial begin
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(negedge clk);
		run_config(28'h0000100, 4'd0, 4'd3, 1'b0, 16'd4, 6);
		run_config(28'h003ff40, 4'd7, 4'ha, 1'b1, 16'd5, 5); // Crosses the window top.
		run_config(28'h0002000, 4'd15, 4'd5, 1'b0, 16'd3, 2);
		repeat (4) @(negedge clk);
		if (dut_i.sva_i.fail_cnt == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("Result: FAILED");
			$fatal(1, "Checks failed");
		end
	end

endmodule

//--- sim/ddr3_wr_sva.sv
`include "ddr3_wr_defs.svh"

module ddr3_wr_sva (
	input logic clk,
	input logic rst_n,
	input logic reg_we,
	input ddr3_wr_pkg::reg_addr_t reg_addr,
	input ddr3_wr_pkg::reg_data_t reg_wdata,
	input ddr3_wr_pkg::reg_data_t reg_rdata,
	input ddr3_wr_pkg::ddr_addr_t axi_awaddr,
	input ddr3_wr_pkg::burst_len_t axi_awlen,
	input ddr3_wr_pkg::burst_id_t axi_awuser_id,
	input logic axi_awuser_ap,
	input logic axi_awvalid,
	input logic axi_awready,
	input ddr3_wr_pkg::ddr_data_t axi_wdata,
	input ddr3_wr_pkg::ddr_strb_t axi_wstrb,
	input logic axi_wready,
	input logic busy,
	input logic done
);
	import ddr3_wr_pkg::*;

	int fail_cnt = 0;
	ddr_addr_t cfg_base;
	burst_len_t cfg_len;
	burst_id_t cfg_id;
	logic cfg_ap;
	burst_cnt_t cfg_count;
	burst_cnt_t run_count; // Count of the run that last finished.
	burst_cnt_t hs_cnt;
	logic [`DDR3_SPACE_AW-1:0] exp_off;
	logic [4:0] beats; // Beats taken since the last address handshake.
	burst_len_t last_len;
	logic hs_seen;
	logic done_q;
	logic aw_fire;

	assign aw_fire = axi_awvalid && axi_awready;

	// Mirror of the configuration as software wrote it.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg_base <= '0;
			{cfg_ap, cfg_id, cfg_len} <= '0;
			cfg_count <= '0;
			run_count <= '0;
			hs_cnt <= '0;
			exp_off <= '0;
			beats <= '0;
			last_len <= '0;
			hs_seen <= 1'b0;
			done_q <= 1'b0;
		end else begin
			if (reg_we && reg_addr == 2'd0)
				cfg_base <= ddr_addr_t'(reg_wdata);
			if (reg_we && reg_addr == 2'd1)
				{cfg_ap, cfg_id, cfg_len} <= reg_wdata[8:0];
			if (reg_we && reg_addr == 2'd2)
				cfg_count <= burst_cnt_t'(reg_wdata);
			if (reg_we && reg_addr == 2'd3 && reg_wdata[0]) begin
				hs_cnt <= '0;
				exp_off <= cfg_base[`DDR3_SPACE_AW-1:0];
			end else if (aw_fire) begin
				hs_cnt <= hs_cnt + 16'd1;
				exp_off <= exp_off + `DDR3_SPACE_AW'((int'(cfg_len) + 1) * `DDR3_ADDR_STEP);
			end
			if (aw_fire) begin
				beats <= '0;
				last_len <= axi_awlen;
				hs_seen <= 1'b1;
			end else if (axi_wready) begin
				beats <= beats + 5'd1;
			end
			done_q <= done;
			if (done && !done_q)
				run_count <= cfg_count;
		end
	end

	reset_quiet: assert property (@(posedge clk) !rst_n |-> !axi_awvalid && !busy && !done)
		else begin
			$error("Outputs active during reset");
			fail_cnt++;
		end

	aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
		axi_awvalid && !axi_awready |=> axi_awvalid && $stable(axi_awaddr) &&
		$stable(axi_awlen) && $stable(axi_awuser_id) && $stable(axi_awuser_ap))
		else begin
			$error("Address channel changed before its handshake");
			fail_cnt++;
		end

	aw_fields: assert property (@(posedge clk) disable iff (!rst_n)
		axi_awvalid |-> axi_awlen == cfg_len && axi_awuser_id == cfg_id &&
		axi_awuser_ap == cfg_ap)
		else begin
			$error("[ERROR] %0t axi_awlen/id/ap got %h/%h/%b expected %h/%h/%b", $time,
				axi_awlen, axi_awuser_id, axi_awuser_ap, cfg_len, cfg_id, cfg_ap);
			fail_cnt++;
		end

	aw_addr: assert property (@(posedge clk) disable iff (!rst_n)
		aw_fire |-> axi_awaddr == ddr_addr_t'(exp_off))
		else begin
			$error("[ERROR] %0t axi_awaddr got %h expected %h", $time, axi_awaddr, exp_off);
			fail_cnt++;
		end

	aw_gap: assert property (@(posedge clk) disable iff (!rst_n)
		aw_fire && hs_seen |-> beats == 5'(last_len) + 5'd1)
		else begin
			$error("[ERROR] %0t beats got %0d expected %0d", $time, beats, last_len + 1);
			fail_cnt++;
		end

	w_lanes: assert property (@(posedge clk) disable iff (!rst_n)
		axi_wstrb == '1 && axi_wdata == {8{axi_wdata[15:0]}})
		else begin
			$error("[ERROR] %0t axi_wdata got %h expected %h", $time, axi_wdata,
				{8{axi_wdata[15:0]}});
			fail_cnt++;
		end

	w_step: assert property (@(posedge clk) disable iff (!rst_n)
		axi_wdata[15:0] != $past(axi_wdata[15:0]) |->
		axi_wdata[15:0] == $past(axi_wdata[15:0]) + 16'd1)
		else begin
			$error("[ERROR] %0t axi_wdata lane got %h expected %h", $time,
				axi_wdata[15:0], $past(axi_wdata[15:0]) + 16'd1);
			fail_cnt++;
		end

	done_count: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(done) |-> hs_cnt == cfg_count)
		else begin
			$error("[ERROR] %0t handshakes got %0d expected %0d", $time, hs_cnt, cfg_count);
			fail_cnt++;
		end

	status_count: assert property (@(posedge clk) disable iff (!rst_n)
		$past(reg_addr) == 2'd3 && reg_rdata[1] |-> reg_rdata[31:16] == run_count)
		else begin
			$error("[ERROR] %0t reg_rdata[31:16] got %0d expected %0d", $time,
				reg_rdata[31:16], run_count);
			fail_cnt++;
		end

endmodule

bind ddr3_wr_top ddr3_wr_sva sva_i (
	.clk(clk), .rst_n(rst_n), .reg_we(reg_we), .reg_addr(reg_addr),
	.reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
	.axi_awaddr(axi_awaddr), .axi_awlen(axi_awlen), .axi_awuser_id(axi_awuser_id),
	.axi_awuser_ap(axi_awuser_ap), .axi_awvalid(axi_awvalid), .axi_awready(axi_awready),
	.axi_wdata(axi_wdata), .axi_wstrb(axi_wstrb), .axi_wready(axi_wready),
	.busy(busy), .done(done)
);

//--- hw/ddr3_wr_top.sv
module ddr3_wr_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    reg_we,
	input  ddr3_wr_pkg::reg_addr_t  reg_addr,
	input  ddr3_wr_pkg::reg_data_t  reg_wdata,
	output ddr3_wr_pkg::reg_data_t  reg_rdata,
	output ddr3_wr_pkg::ddr_addr_t  axi_awaddr,
	output ddr3_wr_pkg::burst_len_t axi_awlen,
	output ddr3_wr_pkg::burst_id_t  axi_awuser_id,
	output logic                    axi_awuser_ap,
	output logic                    axi_awvalid,
	input  logic                    axi_awready,
	output ddr3_wr_pkg::ddr_data_t  axi_wdata,
	output ddr3_wr_pkg::ddr_strb_t  axi_wstrb,
	input  logic                    axi_wready,
	input  ddr3_wr_pkg::burst_id_t  axi_wusero_id,
	input  logic                    axi_wusero_last
);
	import ddr3_wr_pkg::*;

	logic start;
	logic burst_ap;
	logic busy;
	logic done;
	logic write_en;
	logic write_done_p;
	logic ddr3_wr_req;
	ddr_addr_t base_addr;
	ddr_addr_t wr_addr;
	burst_cnt_t burst_num;
	burst_cnt_t bursts_done;
	burst_len_t burst_len;
	burst_id_t burst_id;
	ddr_data_t ddr3_wr_data;

	ddr3_wr_cfg_regs cfg_regs_i (
		.clk, .rst_n, .reg_we, .reg_addr, .reg_wdata, .reg_rdata,
		.busy, .done, .bursts_done,
		.start, .base_addr, .burst_num, .burst_len, .burst_id, .burst_ap
	);

	ddr3_wr_seq seq_i (
		.clk, .rst_n, .start, .base_addr, .burst_num, .burst_len, .write_done_p,
		.write_en, .wr_addr, .busy, .done, .bursts_done
	);

	ddr3_wr_ctrl ctrl_i (
		.clk, .rst_n, .write_en, .write_done_p,
		.ddr3_wr_addr(wr_addr), .ddr3_wr_data, .ddr3_wr_req,
		.ddr3_axi_id(burst_id), .ddr3_axi_len(burst_len), .ddr3_axi_ap(burst_ap),
		.axi_awaddr, .axi_awuser_ap, .axi_awuser_id, .axi_awlen,
		.axi_awready, .axi_awvalid,
		.axi_wdata, .axi_wstrb, .axi_wready, .axi_wusero_id, .axi_wusero_last
	);

	ddr3_wr_pattern_gen pattern_gen_i (
		.clk, .rst_n, .ddr3_wr_req, .ddr3_wr_data
	);

endmodule

//--- hw/ddr3_wr_pattern_gen.sv
`include "ddr3_wr_defs.svh"

module ddr3_wr_pattern_gen (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   ddr3_wr_req,
	output ddr3_wr_pkg::ddr_data_t ddr3_wr_data
);

	localparam int LANES = `DDR3_DATA_W / `DDR3_DQ_W;

	logic [`DDR3_DQ_W-1:0] seq_word;

	// The word moves on once per fetched beat.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			seq_word <= '0;
		else if (ddr3_wr_req)
			seq_word <= seq_word + 1'b1;
	end

	// Every DQ lane carries the same count, so a stuck or swapped lane shows
	// up directly against its neighbours.
	assign ddr3_wr_data = {LANES{seq_word}};

endmodule

//--- hw/ddr3_wr_ctrl.sv
module ddr3_wr_ctrl (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    write_en,
	output logic                    write_done_p,
	input  ddr3_wr_pkg::ddr_addr_t  ddr3_wr_addr,
	input  ddr3_wr_pkg::ddr_data_t  ddr3_wr_data,
	output logic                    ddr3_wr_req,
	input  ddr3_wr_pkg::burst_id_t  ddr3_axi_id,
	input  ddr3_wr_pkg::burst_len_t ddr3_axi_len,
	input  logic                    ddr3_axi_ap,
	output ddr3_wr_pkg::ddr_addr_t  axi_awaddr,
	output logic                    axi_awuser_ap,
	output ddr3_wr_pkg::burst_id_t  axi_awuser_id,
	output ddr3_wr_pkg::burst_len_t axi_awlen,
	input  logic                    axi_awready,
	output logic                    axi_awvalid,
	output ddr3_wr_pkg::ddr_data_t  axi_wdata,
	output ddr3_wr_pkg::ddr_strb_t  axi_wstrb,
	input  logic                    axi_wready,
	input  ddr3_wr_pkg::burst_id_t  axi_wusero_id,
	input  logic                    axi_wusero_last
);

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_ADDR,
		WR_END
	} wr_state_t;

	wr_state_t wr_state;
	logic [15:0] req_wr_cnt; // Beats promised by address handshakes.
	logic [15:0] exec_wr_cnt; // Beats taken by the controller.
	logic write_finished;
	logic aw_fire;

	assign aw_fire = axi_awvalid && axi_awready;
	assign write_finished = (req_wr_cnt == exec_wr_cnt);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_state <= WR_IDLE;
			axi_awaddr <= '0;
			axi_awuser_ap <= 1'b0;
			axi_awuser_id <= '0;
			axi_awlen <= '0;
			axi_awvalid <= 1'b0;
			write_done_p <= 1'b0;
		end else begin
			case (wr_state)
				WR_IDLE: begin
					// A new burst waits until every earlier beat has gone out.
					if (write_en && write_finished) begin
						axi_awaddr <= ddr3_wr_addr;
						axi_awuser_id <= ddr3_axi_id;
						axi_awlen <= ddr3_axi_len;
						axi_awuser_ap <= ddr3_axi_ap;
						wr_state <= WR_ADDR;
					end
				end
				WR_ADDR: begin
					axi_awvalid <= 1'b1;
					if (aw_fire) begin
						axi_awvalid <= 1'b0;
						write_done_p <= 1'b1;
						wr_state <= WR_END;
					end
				end
				WR_END: begin
					write_done_p <= 1'b0;
					if (write_finished)
						wr_state <= WR_IDLE;
				end
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_wr_cnt <= '0;
			exec_wr_cnt <= '0;
		end else begin
			if (aw_fire)
				req_wr_cnt <= req_wr_cnt + 16'(axi_awlen) + 16'd1;
			if (axi_wready)
				exec_wr_cnt <= exec_wr_cnt + 16'd1;
		end
	end

	// The first beat is fetched at the handshake, the rest as each beat of this burst is taken.
	always_comb begin
		ddr3_wr_req = 1'b0;
		if (wr_state == WR_ADDR && aw_fire)
			ddr3_wr_req = 1'b1;
		else if (wr_state == WR_END && axi_wready && !axi_wusero_last &&
			axi_wusero_id == axi_awuser_id)
			ddr3_wr_req = 1'b1;
	end

	assign axi_wdata = ddr3_wr_data;
	assign axi_wstrb = '1; // Full beats only.

endmodule

//--- hw/ddr3_wr_seq.sv
`include "ddr3_wr_defs.svh"

module ddr3_wr_seq (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start,
	input  ddr3_wr_pkg::ddr_addr_t  base_addr,
	input  ddr3_wr_pkg::burst_cnt_t burst_num,
	input  ddr3_wr_pkg::burst_len_t burst_len,
	input  logic                    write_done_p,
	output logic                    write_en,
	output ddr3_wr_pkg::ddr_addr_t  wr_addr,
	output logic                    busy,
	output logic                    done,
	output ddr3_wr_pkg::burst_cnt_t bursts_done
);
	import ddr3_wr_pkg::*;

	seq_state_t state;
	logic [`DDR3_SPACE_AW-1:0] span;
	logic [`DDR3_SPACE_AW-1:0] next_off;
	logic last_burst;

	// One burst covers (len + 1) beats; the offset wraps inside the tested window.
	assign span = (`DDR3_SPACE_AW'(burst_len) + 1'b1) * `DDR3_SPACE_AW'(`DDR3_ADDR_STEP);
	assign next_off = wr_addr[`DDR3_SPACE_AW-1:0] + span;
	assign last_burst = (bursts_done + 1'b1 == burst_num);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= SEQ_IDLE;
			write_en <= 1'b0;
			wr_addr <= '0;
			bursts_done <= '0;
		end else begin
			case (state)
				SEQ_IDLE, SEQ_DONE: begin
					if (start) begin
						bursts_done <= '0;
						wr_addr <= ddr_addr_t'(base_addr[`DDR3_SPACE_AW-1:0]);
						if (burst_num == '0) begin
							state <= SEQ_DONE; // Nothing to write.
						end else begin
							state <= SEQ_ISSUE;
							write_en <= 1'b1;
						end
					end
				end
				SEQ_ISSUE: begin
					if (write_done_p) begin // Address accepted by the controller.
						write_en <= 1'b0;
						bursts_done <= bursts_done + 1'b1;
						wr_addr <= ddr_addr_t'(next_off);
						state <= last_burst ? SEQ_DONE : SEQ_WAIT;
					end
				end
				SEQ_WAIT: begin
					write_en <= 1'b1;
					state <= SEQ_ISSUE;
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	assign busy = (state == SEQ_ISSUE) || (state == SEQ_WAIT);
	assign done = (state == SEQ_DONE); // Held until the next start.

endmodule

//--- hw/ddr3_wr_cfg_regs.sv
module ddr3_wr_cfg_regs (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   reg_we,
	input  ddr3_wr_pkg::reg_addr_t reg_addr,
	input  ddr3_wr_pkg::reg_data_t reg_wdata,
	output ddr3_wr_pkg::reg_data_t reg_rdata,
	input  logic                   busy,
	input  logic                   done,
	input  ddr3_wr_pkg::burst_cnt_t bursts_done,
	output logic                   start,
	output ddr3_wr_pkg::ddr_addr_t base_addr,
	output ddr3_wr_pkg::burst_cnt_t burst_num,
	output ddr3_wr_pkg::burst_len_t burst_len,
	output ddr3_wr_pkg::burst_id_t burst_id,
	output logic                   burst_ap
);
	import ddr3_wr_pkg::*;

	localparam reg_addr_t REG_BASE = 2'd0;
	localparam reg_addr_t REG_BURST = 2'd1;
	localparam reg_addr_t REG_COUNT = 2'd2;
	localparam reg_addr_t REG_CTRL = 2'd3;

	logic cfg_lock;

	// A pending start counts as busy so the sequencer never sees a half-changed setup.
	assign cfg_lock = busy | start;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			start <= 1'b0;
			base_addr <= '0;
			burst_num <= '0;
			burst_len <= '0;
			burst_id <= '0;
			burst_ap <= 1'b0;
		end else begin
			start <= reg_we && (reg_addr == REG_CTRL) && reg_wdata[0];
			if (reg_we && !cfg_lock) begin
				case (reg_addr)
					REG_BASE: base_addr <= ddr_addr_t'(reg_wdata);
					REG_BURST: begin
						burst_len <= reg_wdata[3:0];
						burst_id <= reg_wdata[7:4];
						burst_ap <= reg_wdata[8];
					end
					REG_COUNT: burst_num <= burst_cnt_t'(reg_wdata);
					default: ; // The control word only carries the start bit.
				endcase
			end
		end
	end

	// Read data follows the address by one cycle.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reg_rdata <= '0;
		end else begin
			case (reg_addr)
				REG_BASE: reg_rdata <= reg_data_t'(base_addr);
				REG_BURST: reg_rdata <= reg_data_t'({burst_ap, burst_id, burst_len});
				REG_COUNT: reg_rdata <= reg_data_t'(burst_num);
				default: reg_rdata <= {bursts_done, 14'd0, done, busy};
			endcase
		end
	end

endmodule

//--- hw/ddr3_wr_pkg.sv
`include "ddr3_wr_defs.svh"

package ddr3_wr_pkg;

	typedef logic [`DDR3_ADDR_W-1:0] ddr_addr_t;
	typedef logic [`DDR3_DATA_W-1:0] ddr_data_t;
	typedef logic [`DDR3_DATA_W/8-1:0] ddr_strb_t;

	typedef logic [3:0] burst_len_t; // AXI length, beats minus one.
	typedef logic [3:0] burst_id_t;
	typedef logic [15:0] burst_cnt_t;

	typedef logic [`DDR3_REG_W-1:0] reg_data_t;
	typedef logic [`DDR3_REG_AW-1:0] reg_addr_t;

	// Burst sequencer states.
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_ISSUE,
		SEQ_WAIT,
		SEQ_DONE
	} seq_state_t;

endpackage

//--- hw/ddr3_wr_defs.svh
`ifndef DDR3_WR_DEFS_SVH
`define DDR3_WR_DEFS_SVH

// Controller address and memory data widths.
`define DDR3_ADDR_W 28
`define DDR3_DQ_W 16
`define DDR3_DATA_W 128

// The tested window is 2**DDR3_SPACE_AW address units.
`define DDR3_SPACE_AW 18
`define DDR3_ADDR_STEP 8 // Address units covered by one beat.

// Software register port.
`define DDR3_REG_W 32
`define DDR3_REG_AW 2

`endif
